// File: Makefile
VERILATOR ?= verilator
TOP ?= tbControlUnit
FLAGS ?= --binary --timing --assert
OBJDIR ?= obj_dir
FILELIST ?= tb.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := verilog/mips_defs.svh
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// File: dv/tbControlUnit.sv
`include "mips_defs.svh"

module tbControlUnit;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int instructionCount = 400;
	localparam int startTimeout = 64;

	// Instruction kinds picked by the stimulus
	localparam int kAdd = 0;
	localparam int kAnd = 1;
	localparam int kSub = 2;
	localparam int kSlt = 3;
	localparam int kMult = 4;
	localparam int kBadFunct = 5;
	localparam int kAddiOvf = 6;
	localparam int kAddi = 7;
	localparam int kAddiu = 8;
	localparam int kLui = 9;
	localparam int kBeq = 10;
	localparam int kBne = 11;
	localparam int kBgt = 12;
	localparam int kBle = 13;
	localparam int kLw = 14;
	localparam int kLh = 15;
	localparam int kLb = 16;
	localparam int kBadOp = 17;
	localparam int kindCount = 18;

	logic clock;
	logic reset;
	isaPkg::opcode_t opCode;
	isaPkg::funct_t funct;
	logic overflow;
	logic equal;
	logic greater;
	controlPkg::aluSrcA_t aluSrcA;
	controlPkg::aluSrcB_t aluSrcB;
	controlPkg::aluOp_t aluOp;
	controlPkg::pcSource_t pcSource;
	controlPkg::memAddrSel_t memAddrSel;
	controlPkg::memToReg_t memToReg;
	controlPkg::regDst_t regDst;
	controlPkg::loadSize_t loadSize;
	logic pcWrite;
	logic irWrite;
	logic writeRegA;
	logic writeRegB;
	logic aluOutWrite;
	logic regWrite;
	logic epcWrite;
	logic memDataWrite;
	logic multControl;
	controlPkg::state_t stateCode;

	logic [31:0] lfsrState = 32'h825bc25d;
	int curKind = kAdd;
	bit covered [kindCount];
	controlPkg::state_t modelState;
	int modelMult;

	controlUnit controlUnit_inst (
		.clock(clock), .reset(reset), .opCode(opCode), .funct(funct),
		.overflow(overflow), .equal(equal), .greater(greater),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp), .pcSource(pcSource),
		.memAddrSel(memAddrSel), .memToReg(memToReg), .regDst(regDst),
		.loadSize(loadSize), .pcWrite(pcWrite), .irWrite(irWrite),
		.writeRegA(writeRegA), .writeRegB(writeRegB), .aluOutWrite(aluOutWrite),
		.regWrite(regWrite), .epcWrite(epcWrite), .memDataWrite(memDataWrite),
		.multControl(multControl), .stateCode(stateCode)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic valueError(input string name, input logic [31:0] got, input logic [31:0] exp);
		failRun($sformatf("ERROR %s got %0h expected %0h", name, got, exp));
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic int drawBits(input int width);
		int value;
		value = 0;
		for (int i = 0; i < width; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		end
		return value;
	endfunction

	function automatic controlPkg::state_t predictNext(controlPkg::state_t s, int kind, int mc);
		case (s)
			controlPkg::stReset: return controlPkg::stStart;
			controlPkg::stStart: return controlPkg::stWaitMemRead;
			controlPkg::stWaitMemRead: return controlPkg::stWaitMemRead2;
			controlPkg::stWaitMemRead2: return controlPkg::stDecode;
			controlPkg::stDecode: begin
				case (kind)
					kAdd: return controlPkg::stAdd;
					kAnd: return controlPkg::stAnd;
					kSub: return controlPkg::stSub;
					kSlt: return controlPkg::stSlt;
					kMult: return controlPkg::stMult;
					kAddiOvf, kAddi: return controlPkg::stAddi;
					kAddiu: return controlPkg::stAddiu;
					kLui: return controlPkg::stLui;
					kBeq: return controlPkg::stBeq;
					kBne: return controlPkg::stBne;
					kBgt: return controlPkg::stBgt;
					kBle: return controlPkg::stBle;
					kLw, kLh, kLb: return controlPkg::stLw;
					default: return controlPkg::stWait;
				endcase
			end
			controlPkg::stAdd, controlPkg::stAnd, controlPkg::stSub: begin
				return controlPkg::stWriteInReg;
			end
			controlPkg::stAddi: begin
				if (kind == kAddiOvf) return controlPkg::stOverflowExc;
				return controlPkg::stWriteInRegAddi;
			end
			controlPkg::stAddiu: return controlPkg::stWriteInRegAddi;
			controlPkg::stLui: return controlPkg::stLui2;
			controlPkg::stBeq: return controlPkg::stBeqCompare;
			controlPkg::stBne: return controlPkg::stBneCompare;
			controlPkg::stBgt: return controlPkg::stBgtCompare;
			controlPkg::stBle: return controlPkg::stBleCompare;
			controlPkg::stLw: return controlPkg::stLGet;
			controlPkg::stLGet: begin
				if (kind == kLh) return controlPkg::stLSaveh;
				if (kind == kLb) return controlPkg::stLSaveb;
				return controlPkg::stLSave;
			end
			controlPkg::stMult: begin
				if (mc == `MULT_CYCLES - 1) return controlPkg::stWait;
				return controlPkg::stMult;
			end
			controlPkg::stWait: return controlPkg::stStart;
			default: return controlPkg::stWait;
		endcase
	endfunction

	function automatic int cyclesFor(int kind);
		case (kind)
			// Fetch and Wait only
			kBadFunct, kBadOp: return 5;
			kSlt: return 6;
			kLw, kLh, kLb: return 8;
			kMult: return 5 + `MULT_CYCLES;
			default: return 7;
		endcase
	endfunction

	function automatic logic writesReg(controlPkg::state_t s);
		return s inside {controlPkg::stReset, controlPkg::stWriteInReg, controlPkg::stSlt,
			controlPkg::stWriteInRegAddi, controlPkg::stLui2, controlPkg::stLSave,
			controlPkg::stLSaveh, controlPkg::stLSaveb};
	endfunction

	function automatic logic branchTaken(controlPkg::state_t s, logic eq, logic gt);
		case (s)
			controlPkg::stBeqCompare: return eq;
			controlPkg::stBneCompare: return !eq;
			controlPkg::stBgtCompare: return gt;
			default: return !gt;
		endcase
	endfunction

	function automatic controlPkg::aluOp_t expectedAluOp(controlPkg::state_t s);
		case (s)
			controlPkg::stAnd: return controlPkg::aluAnd;
			controlPkg::stSub: return controlPkg::aluSub;
			default: return controlPkg::aluAdd;
		endcase
	endfunction

	function automatic controlPkg::loadSize_t expectedLoadSize(controlPkg::state_t s);
		case (s)
			controlPkg::stLSaveh: return controlPkg::sizeHalf;
			controlPkg::stLSaveb: return controlPkg::sizeByte;
			default: return controlPkg::sizeWord;
		endcase
	endfunction

	always @(posedge clock or posedge reset) begin
		if (reset) begin
			modelState <= controlPkg::stReset;
			modelMult <= 0;
		end else begin
			modelState <= predictNext(modelState, curKind, modelMult);
			modelMult <= (modelState == controlPkg::stMult) ? modelMult + 1 : 0;
		end
	end

	assert property (@(posedge clock) stateCode == modelState)
		else valueError("stateCode", $sampled(stateCode), $sampled(modelState));
	assert property (@(posedge clock) regWrite == writesReg(modelState))
		else valueError("regWrite", $sampled(regWrite), writesReg($sampled(modelState)));
	assert property (@(posedge clock) multControl == (modelState == controlPkg::stMult))
		else failRun("multControl does not match the Mult state");
	assert property (@(posedge clock) modelState == controlPkg::stReset |->
		epcWrite && regDst == controlPkg::dstStackPointer && !pcWrite && !irWrite
		&& !writeRegA && !writeRegB && !aluOutWrite && !memDataWrite)
		else failRun("reset state drives the wrong enables");
	assert property (@(posedge clock) modelState == controlPkg::stStart |->
		pcWrite && aluSrcA == controlPkg::srcAPc && aluSrcB == controlPkg::srcBFour
		&& aluOp == controlPkg::aluAdd)
		else failRun("fetch does not increment the PC in Start");
	assert property (@(posedge clock) irWrite == (modelState == controlPkg::stWaitMemRead2))
		else valueError("irWrite", $sampled(irWrite), !$sampled(irWrite));
	assert property (@(posedge clock) modelState == controlPkg::stDecode |-> writeRegA && writeRegB)
		else failRun("Decode does not load registers A and B");
	assert property (@(posedge clock)
		modelState inside {controlPkg::stAdd, controlPkg::stAnd, controlPkg::stSub} |->
		aluOp == expectedAluOp(modelState))
		else valueError("aluOp", $sampled(aluOp), expectedAluOp($sampled(modelState)));
	assert property (@(posedge clock)
		modelState inside {controlPkg::stAdd, controlPkg::stAnd, controlPkg::stSub} |->
		aluOutWrite)
		else failRun("ALU operation does not latch its result into ALUOut");
	assert property (@(posedge clock) modelState inside {controlPkg::stWriteInReg,
		controlPkg::stSlt} |-> regDst == controlPkg::dstRd)
		else valueError("regDst", $sampled(regDst), controlPkg::dstRd);
	assert property (@(posedge clock) modelState == controlPkg::stSlt |->
		memToReg == controlPkg::wbLessThan)
		else valueError("memToReg", $sampled(memToReg), controlPkg::wbLessThan);
	assert property (@(posedge clock) modelState == controlPkg::stOverflowExc |->
		epcWrite && memAddrSel == controlPkg::addrExceptionVector)
		else failRun("overflow exception does not save EPC or select the vector");
	assert property (@(posedge clock) modelState inside {controlPkg::stWriteInRegAddi,
		controlPkg::stLui2} |-> regDst == controlPkg::dstRt)
		else valueError("regDst", $sampled(regDst), controlPkg::dstRt);
	assert property (@(posedge clock) modelState inside {controlPkg::stBeqCompare,
		controlPkg::stBneCompare, controlPkg::stBgtCompare, controlPkg::stBleCompare} |->
		pcWrite == branchTaken(modelState, equal, greater) && pcSource == controlPkg::pcAluOut)
		else valueError("pcWrite", $sampled(pcWrite),
			branchTaken($sampled(modelState), $sampled(equal), $sampled(greater)));
	assert property (@(posedge clock) memDataWrite == (modelState == controlPkg::stLGet))
		else valueError("memDataWrite", $sampled(memDataWrite), !$sampled(memDataWrite));
	assert property (@(posedge clock) modelState == controlPkg::stLGet |->
		memAddrSel == controlPkg::addrAluOut)
		else valueError("memAddrSel", $sampled(memAddrSel), controlPkg::addrAluOut);
	assert property (@(posedge clock) modelState inside {controlPkg::stLSave,
		controlPkg::stLSaveh, controlPkg::stLSaveb} |-> memToReg == controlPkg::wbMemory)
		else valueError("memToReg", $sampled(memToReg), controlPkg::wbMemory);
	assert property (@(posedge clock) loadSize == expectedLoadSize(modelState))
		else valueError("loadSize", $sampled(loadSize), expectedLoadSize($sampled(modelState)));
	assert property (@(posedge clock) modelState == controlPkg::stWait |->
		!pcWrite && !irWrite && !writeRegA && !writeRegB && !aluOutWrite && !regWrite
		&& !epcWrite && !memDataWrite && !multControl)
		else failRun("Wait state drives a write enable");

	task automatic waitForStart(output int cycles);
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (cycles > startTimeout) begin
				failRun("timed out waiting for the Start state");
			end
		end while (stateCode != controlPkg::stStart);
	endtask

	task automatic applyInstruction(input int kind);
		int flags;
		flags = drawBits(2);
		case (kind)
			kAdd, kAnd, kSub, kSlt, kMult, kBadFunct: opCode <= isaPkg::opRType;
			kAddiOvf, kAddi: opCode <= isaPkg::opAddi;
			kAddiu: opCode <= isaPkg::opAddiu;
			kLui: opCode <= isaPkg::opLui;
			kBeq: opCode <= isaPkg::opBeq;
			kBne: opCode <= isaPkg::opBne;
			kBgt: opCode <= isaPkg::opBgt;
			kBle: opCode <= isaPkg::opBle;
			kLw: opCode <= isaPkg::opLw;
			kLh: opCode <= isaPkg::opLh;
			kLb: opCode <= isaPkg::opLb;
			default: opCode <= isaPkg::opcode_t'(6'h02);
		endcase
		case (kind)
			kAnd: funct <= isaPkg::fnAnd;
			kSub: funct <= isaPkg::fnSub;
			kSlt: funct <= isaPkg::fnSlt;
			kMult: funct <= isaPkg::fnMult;
			kBadFunct: funct <= isaPkg::funct_t'(6'h08);
			default: funct <= isaPkg::fnAdd;
		endcase
		overflow <= (kind == kAddiOvf);
		equal <= flags[0];
		greater <= flags[1];
		curKind <= kind;
	endtask

	initial begin
		int cycles;
		int kind;
		int prevKind;
		bit allCovered;
		reset = 1'b1;
		opCode = isaPkg::opRType;
		funct = isaPkg::fnAdd;
		overflow = 1'b0;
		equal = 1'b0;
		greater = 1'b0;
		prevKind = -1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i <= instructionCount; i++) begin
			waitForStart(cycles);
			assert (prevKind < 0 || cycles == cyclesFor(prevKind))
				else valueError("instruction cycles", cycles, cyclesFor(prevKind));
			if (i == instructionCount) begin
				break;
			end
			kind = drawBits(5) % kindCount;
			covered[kind] = 1'b1;
			@(posedge clock);
			applyInstruction(kind);
			prevKind = kind;
		end
		allCovered = 1'b1;
		foreach (covered[k]) begin
			allCovered &= covered[k];
		end
		if (allCovered) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			failRun("some instruction kinds were never exercised");
		end
	end

endmodule

// File: tb.f
+incdir+verilog
verilog/isaPkg.sv
verilog/controlPkg.sv
verilog/instructionDecoder.sv
verilog/stateSequencer.sv
verilog/multiplyTimer.sv
verilog/controlSignalDecoder.sv
verilog/controlUnit.sv
dv/tbControlUnit.sv

// File: verilog/controlPkg.sv
`include "mips_defs.svh"

package controlPkg;

	typedef enum logic [`STATE_WIDTH-1:0] {
		stReset = 7'd1,
		stStart = 7'd2,
		stWaitMemRead = 7'd3,
		stDecode = 7'd4,
		stAdd = 7'd5,
		stWriteInReg = 7'd6,
		stWait = 7'd7,
		stAddi = 7'd8,
		stWriteInRegAddi = 7'd9,
		stWaitMemRead2 = 7'd10,
		stAnd = 7'd11,
		stSub = 7'd12,
		stSlt = 7'd32,
		stOverflowExc = 7'd33,
		stAddiu = 7'd34,
		stBeq = 7'd35,
		stBeqCompare = 7'd36,
		stBne = 7'd37,
		stBneCompare = 7'd38,
		stBgt = 7'd39,
		stBgtCompare = 7'd40,
		stBle = 7'd41,
		stBleCompare = 7'd42,
		stLw = 7'd43,
		stLGet = 7'd44,
		stLSave = 7'd45,
		stLSaveh = 7'd46,
		stLSaveb = 7'd47,
		stLui = 7'd48,
		stLui2 = 7'd49,
		stMult = 7'd60
	} state_t;

	// Only execute entry states and stWait are ever produced
	typedef state_t entryState_t;

	typedef enum logic [1:0] {srcAPc = 2'd0, srcAUpperImm = 2'd1, srcARegA = 2'd2} aluSrcA_t;

	typedef enum logic [2:0] {
		srcBRegB = 3'd0,
		srcBFour = 3'd1,
		srcBSignImm = 3'd2,
		srcBBranchOffset = 3'd3
	} aluSrcB_t;

	// Compare drives the equal and greater flags
	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluCompare = 3'd7
	} aluOp_t;

	typedef enum logic [2:0] {pcAluResult = 3'd0, pcAluOut = 3'd1} pcSource_t;

	typedef enum logic [2:0] {
		addrPc = 3'd0,
		addrAluOut = 3'd1,
		addrExceptionVector = 3'd3
	} memAddrSel_t;

	typedef enum logic [3:0] {wbAluOut = 4'd0, wbMemory = 4'd3, wbLessThan = 4'd8} memToReg_t;

	typedef enum logic [1:0] {dstRt = 2'd0, dstStackPointer = 2'd1, dstRd = 2'd3} regDst_t;

	typedef enum logic [1:0] {sizeWord = 2'd0, sizeHalf = 2'd1, sizeByte = 2'd2} loadSize_t;

endpackage

// File: verilog/controlSignalDecoder.sv
module controlSignalDecoder (
	input controlPkg::state_t state,
	input logic equal,
	input logic greater,
	output controlPkg::aluSrcA_t aluSrcA,
	output controlPkg::aluSrcB_t aluSrcB,
	output controlPkg::aluOp_t aluOp,
	output controlPkg::pcSource_t pcSource,
	output controlPkg::memAddrSel_t memAddrSel,
	output controlPkg::memToReg_t memToReg,
	output controlPkg::regDst_t regDst,
	output controlPkg::loadSize_t loadSize,
	output logic pcWrite,
	output logic irWrite,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutWrite,
	output logic regWrite,
	output logic epcWrite,
	output logic memDataWrite,
	output logic multControl
);

	always_comb begin
		aluSrcA = controlPkg::srcAPc;
		aluSrcB = controlPkg::srcBRegB;
		aluOp = controlPkg::aluPass;
		pcSource = controlPkg::pcAluResult;
		memAddrSel = controlPkg::addrPc;
		memToReg = controlPkg::wbAluOut;
		regDst = controlPkg::dstRt;
		loadSize = controlPkg::sizeWord;
		pcWrite = 1'b0;
		irWrite = 1'b0;
		writeRegA = 1'b0;
		writeRegB = 1'b0;
		aluOutWrite = 1'b0;
		regWrite = 1'b0;
		epcWrite = 1'b0;
		memDataWrite = 1'b0;
		multControl = 1'b0;

		case (state)
			// Initialise the stack pointer and EPC
			controlPkg::stReset: begin
				regDst = controlPkg::dstStackPointer;
				regWrite = 1'b1;
				epcWrite = 1'b1;
			end
			// PC + 4 while the instruction is read
			controlPkg::stStart: begin
				aluSrcB = controlPkg::srcBFour;
				aluOp = controlPkg::aluAdd;
				pcWrite = 1'b1;
			end
			controlPkg::stWaitMemRead2: irWrite = 1'b1;
			controlPkg::stDecode: begin
				writeRegA = 1'b1;
				writeRegB = 1'b1;
			end
			controlPkg::stAdd, controlPkg::stAnd, controlPkg::stSub: begin
				aluSrcA = controlPkg::srcARegA;
				aluOutWrite = 1'b1;
				case (state)
					controlPkg::stAnd: aluOp = controlPkg::aluAnd;
					controlPkg::stSub: aluOp = controlPkg::aluSub;
					default: aluOp = controlPkg::aluAdd;
				endcase
			end
			controlPkg::stWriteInReg: begin
				regDst = controlPkg::dstRd;
				regWrite = 1'b1;
			end
			// Result comes straight from the less-than flag
			controlPkg::stSlt: begin
				aluSrcA = controlPkg::srcARegA;
				aluOp = controlPkg::aluCompare;
				memToReg = controlPkg::wbLessThan;
				writeRegA = 1'b1;
				writeRegB = 1'b1;
				regDst = controlPkg::dstRd;
				regWrite = 1'b1;
			end
			controlPkg::stAddi, controlPkg::stAddiu: begin
				aluSrcA = controlPkg::srcARegA;
				aluSrcB = controlPkg::srcBSignImm;
				aluOp = controlPkg::aluAdd;
				aluOutWrite = 1'b1;
			end
			controlPkg::stWriteInRegAddi, controlPkg::stLui2: regWrite = 1'b1;
			controlPkg::stOverflowExc: begin
				memAddrSel = controlPkg::addrExceptionVector;
				epcWrite = 1'b1;
			end
			controlPkg::stLui: begin
				aluSrcA = controlPkg::srcAUpperImm;
				aluSrcB = controlPkg::srcBSignImm;
				aluOp = controlPkg::aluAdd;
				aluOutWrite = 1'b1;
			end
			// Branch target into ALUOut ahead of the compare
			controlPkg::stBeq, controlPkg::stBne, controlPkg::stBgt, controlPkg::stBle: begin
				aluSrcB = controlPkg::srcBBranchOffset;
				aluOp = controlPkg::aluAdd;
				aluOutWrite = 1'b1;
			end
			controlPkg::stBeqCompare, controlPkg::stBneCompare,
			controlPkg::stBgtCompare, controlPkg::stBleCompare: begin
				aluSrcA = controlPkg::srcARegA;
				aluOp = controlPkg::aluCompare;
				pcSource = controlPkg::pcAluOut;
				writeRegA = 1'b1;
				writeRegB = 1'b1;
				case (state)
					controlPkg::stBeqCompare: pcWrite = equal;
					controlPkg::stBneCompare: pcWrite = !equal;
					controlPkg::stBgtCompare: pcWrite = greater;
					default: pcWrite = !greater;
				endcase
			end
			controlPkg::stLw: begin
				aluSrcA = controlPkg::srcARegA;
				aluSrcB = controlPkg::srcBSignImm;
				writeRegA = 1'b1;
				aluOutWrite = 1'b1;
			end
			controlPkg::stLGet: begin
				memAddrSel = controlPkg::addrAluOut;
				memDataWrite = 1'b1;
			end
			controlPkg::stLSave, controlPkg::stLSaveh, controlPkg::stLSaveb: begin
				memToReg = controlPkg::wbMemory;
				regWrite = 1'b1;
				if (state == controlPkg::stLSaveh) begin
					loadSize = controlPkg::sizeHalf;
				end else if (state == controlPkg::stLSaveb) begin
					loadSize = controlPkg::sizeByte;
				end
			end
			controlPkg::stMult: multControl = 1'b1;
			default: begin
			end
		endcase
	end

endmodule

// File: verilog/controlUnit.sv
module controlUnit (
	input logic clock,
	input logic reset,
	input isaPkg::opcode_t opCode,
	input isaPkg::funct_t funct,
	input logic overflow,
	input logic equal,
	input logic greater,
	output controlPkg::aluSrcA_t aluSrcA,
	output controlPkg::aluSrcB_t aluSrcB,
	output controlPkg::aluOp_t aluOp,
	output controlPkg::pcSource_t pcSource,
	output controlPkg::memAddrSel_t memAddrSel,
	output controlPkg::memToReg_t memToReg,
	output controlPkg::regDst_t regDst,
	output controlPkg::loadSize_t loadSize,
	output logic pcWrite,
	output logic irWrite,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutWrite,
	output logic regWrite,
	output logic epcWrite,
	output logic memDataWrite,
	output logic multControl,
	output controlPkg::state_t stateCode
);

	controlPkg::entryState_t entryState;
	logic multDone;

	instructionDecoder instructionDecoder_inst (
		.opCode(opCode),
		.funct(funct),
		.entryState(entryState)
	);

	// The state register output doubles as the visible state code
	stateSequencer stateSequencer_inst (
		.clock(clock),
		.reset(reset),
		.entryState(entryState),
		.overflow(overflow),
		.opCode(opCode),
		.multDone(multDone),
		.state(stateCode)
	);

	multiplyTimer multiplyTimer_inst (
		.clock(clock),
		.reset(reset),
		.state(stateCode),
		.multDone(multDone)
	);

	controlSignalDecoder controlSignalDecoder_inst (
		.state(stateCode),
		.equal(equal),
		.greater(greater),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.pcSource(pcSource),
		.memAddrSel(memAddrSel),
		.memToReg(memToReg),
		.regDst(regDst),
		.loadSize(loadSize),
		.pcWrite(pcWrite),
		.irWrite(irWrite),
		.writeRegA(writeRegA),
		.writeRegB(writeRegB),
		.aluOutWrite(aluOutWrite),
		.regWrite(regWrite),
		.epcWrite(epcWrite),
		.memDataWrite(memDataWrite),
		.multControl(multControl)
	);

endmodule

// File: verilog/instructionDecoder.sv
module instructionDecoder (
	input isaPkg::opcode_t opCode,
	input isaPkg::funct_t funct,
	output controlPkg::entryState_t entryState
);

	always_comb begin
		entryState = controlPkg::stWait;
		case (opCode)
			isaPkg::opRType: begin
				case (funct)
					isaPkg::fnAdd: entryState = controlPkg::stAdd;
					isaPkg::fnAnd: entryState = controlPkg::stAnd;
					isaPkg::fnSub: entryState = controlPkg::stSub;
					isaPkg::fnSlt: entryState = controlPkg::stSlt;
					isaPkg::fnMult: entryState = controlPkg::stMult;
					default: entryState = controlPkg::stWait;
				endcase
			end
			isaPkg::opAddi: begin
				entryState = controlPkg::stAddi;
			end
			isaPkg::opAddiu: begin
				entryState = controlPkg::stAddiu;
			end
			isaPkg::opLui: begin
				entryState = controlPkg::stLui;
			end
			isaPkg::opBeq: begin
				entryState = controlPkg::stBeq;
			end
			isaPkg::opBne: begin
				entryState = controlPkg::stBne;
			end
			isaPkg::opBgt: begin
				entryState = controlPkg::stBgt;
			end
			isaPkg::opBle: begin
				entryState = controlPkg::stBle;
			end
			// Load width is resolved later, in LGet
			isaPkg::opLw, isaPkg::opLh, isaPkg::opLb: begin
				entryState = controlPkg::stLw;
			end
			// Unknown code skips straight to the end of the instruction
			default: begin
				entryState = controlPkg::stWait;
			end
		endcase
	end

endmodule

// File: verilog/isaPkg.sv
`include "mips_defs.svh"

package isaPkg;

	// Primary opcode field in bits 31:26
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		opRType = 6'h00,
		opBeq = 6'h04,
		opBne = 6'h05,
		opBle = 6'h06,
		opBgt = 6'h07,
		opAddi = 6'h08,
		opAddiu = 6'h09,
		opLui = 6'h0f,
		opLb = 6'h20,
		opLh = 6'h21,
		opLw = 6'h23
	} opcode_t;

	// Funct field is only meaningful with opRType
	typedef enum logic [`FUNCT_WIDTH-1:0] {
		fnMult = 6'h18,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnSlt = 6'h2a
	} funct_t;

endpackage

// File: verilog/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6

// Wide enough for state codes up to Mult at 60
`define STATE_WIDTH 7

// Multiply runs a fixed number of cycles, one per operand bit
`define MULT_CYCLES 32
`define MULT_COUNT_WIDTH 6

`endif

// File: verilog/multiplyTimer.sv
`include "mips_defs.svh"

module multiplyTimer (
	input logic clock,
	input logic reset,
	input controlPkg::state_t state,
	output logic multDone
);

	localparam int unsigned lastCount = `MULT_CYCLES - 1;

	logic [`MULT_COUNT_WIDTH-1:0] count;
	logic inMult;

	assign inMult = (state == controlPkg::stMult);

	// Held at zero outside Mult so every multiply starts from a clean count
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (inMult) begin
			count <= count + 1'b1;
		end else begin
			count <= '0;
		end
	end

	assign multDone = inMult && (count == lastCount[`MULT_COUNT_WIDTH-1:0]);

endmodule

// File: verilog/stateSequencer.sv
module stateSequencer (
	input logic clock,
	input logic reset,
	input controlPkg::entryState_t entryState,
	input logic overflow,
	input isaPkg::opcode_t opCode,
	input logic multDone,
	output controlPkg::state_t state
);

	controlPkg::state_t nextState;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= controlPkg::stReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = controlPkg::stWait;
		case (state)
			controlPkg::stReset: nextState = controlPkg::stStart;
			// Fetch with a fixed two-cycle memory latency
			controlPkg::stStart: nextState = controlPkg::stWaitMemRead;
			controlPkg::stWaitMemRead: nextState = controlPkg::stWaitMemRead2;
			controlPkg::stWaitMemRead2: nextState = controlPkg::stDecode;
			controlPkg::stDecode: nextState = entryState;
			controlPkg::stAdd, controlPkg::stAnd, controlPkg::stSub: begin
				nextState = controlPkg::stWriteInReg;
			end
			controlPkg::stAddi: begin
				if (overflow) begin
					nextState = controlPkg::stOverflowExc;
				end else begin
					nextState = controlPkg::stWriteInRegAddi;
				end
			end
			controlPkg::stAddiu: nextState = controlPkg::stWriteInRegAddi;
			controlPkg::stLui: nextState = controlPkg::stLui2;
			controlPkg::stBeq: nextState = controlPkg::stBeqCompare;
			controlPkg::stBne: nextState = controlPkg::stBneCompare;
			controlPkg::stBgt: nextState = controlPkg::stBgtCompare;
			controlPkg::stBle: nextState = controlPkg::stBleCompare;
			controlPkg::stLw: nextState = controlPkg::stLGet;
			controlPkg::stLGet: begin
				case (opCode)
					isaPkg::opLb: nextState = controlPkg::stLSaveb;
					isaPkg::opLh: nextState = controlPkg::stLSaveh;
					default: nextState = controlPkg::stLSave;
				endcase
			end
			controlPkg::stMult: begin
				if (multDone) begin
					nextState = controlPkg::stWait;
				end else begin
					nextState = controlPkg::stMult;
				end
			end
			controlPkg::stWait: nextState = controlPkg::stStart;
			// Write-back, exception and compare states all end here
			default: nextState = controlPkg::stWait;
		endcase
	end

endmodule
